// File: cache_l1.f
verilog/cache_cfg_pkg.sv
verilog/cache_bus_pkg.sv
verilog/way_ram.sv
verilog/way_use_counters.sv
verilog/way_datapath.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
test/tb_clock_gen.sv
test/tb_cache_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the L1 cache simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_top \
    -f cache_l1.f -o sim_cache > build.log 2>&1 \
    && ./obj_dir/sim_cache > sim.log 2>&1 \
    || { echo "build or simulation run did not complete"; exit 1; }
if grep -q "Regression failed" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi
echo "simulation finished, see sim.log"
exit 0

// File: test/tb_cache_top.sv
// cache testbench with memory model, reference model, stimulus and checks
`timescale 1ns/1ps

module tb_cache_top
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
();

    localparam logic [31:0] SEED    = 32'h0112_3014;
    localparam int          TIMEOUT = 500;

    typedef struct packed {
        logic       rw;
        line_addr_t addr;
        line_t      data;
    } mem_op_t;

    typedef struct packed {
        logic  rd;
        word_t data;
    } rd_exp_t;

    logic      sys_clk;
    logic      rstn;
    cpu_req_t  cpu_req;
    cpu_res_t  cpu_res;
    mem_req_t  mem_req;
    mem_resp_t mem_resp;

    int          value_errors;
    int          timeout_errors;
    logic [31:0] stim_rng;
    logic [31:0] mem_rng;

    line_t   mem_lines [line_addr_t];
    line_t   gold [line_addr_t];
    logic    ref_valid [NUM_SETS][NUM_WAYS];
    logic    ref_dirty [NUM_SETS][NUM_WAYS];
    tag_t    ref_tag [NUM_SETS][NUM_WAYS];
    int      ref_cnt [NUM_SETS][NUM_WAYS];
    mem_op_t exp_mem [$];
    mem_op_t got_mem [$];
    rd_exp_t exp_rd [$];

    tb_clock_gen u_clock_gen (
        .sys_clk (sys_clk),
        .rstn    (rstn)
    );

    cache_top u_cache_top (
        .sys_clk  (sys_clk),
        .rstn     (rstn),
        .cpu_req  (cpu_req),
        .mem_resp (mem_resp),
        .cpu_res  (cpu_res),
        .mem_req  (mem_req)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // every word of untouched memory depends on the full line address
    function automatic line_t pattern_line(input line_addr_t la);
        line_t l;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            l[w*WORD_W +: WORD_W] = ({7'h0, la} * 32'h9E37_79B1) ^ (32'(w) << 28) ^ 32'hA5A5_0F0F;
        end
        return l;
    endfunction

    function automatic line_t gold_line(input line_addr_t la);
        return gold.exists(la) ? gold[la] : pattern_line(la);
    endfunction

    function automatic addr_t make_addr(input tag_t t, input index_t ix, input offset_t o);
        return {t, ix, o};
    endfunction

    function automatic word_t expected_word(input addr_t a);
        line_t l;
        l = gold_line(a[ADDR_W-1:OFFSET_W]);
        return l[a[OFFSET_W-1:0]*WORD_W +: WORD_W];
    endfunction

    // lowest invalid way or else the lowest count with ties to the lower way
    function automatic way_t expected_victim(input index_t ix);
        way_t v;
        int   min_cnt;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (!ref_valid[ix][w])
            begin
                return way_t'(w);
            end
        end
        v       = '0;
        min_cnt = ref_cnt[ix][0];
        for (int w = 1; w < NUM_WAYS; w++)
        begin
            if (ref_cnt[ix][w] < min_cnt)
            begin
                min_cnt = ref_cnt[ix][w];
                v       = way_t'(w);
            end
        end
        return v;
    endfunction

    task automatic ref_access(input addr_t a, input logic rw, input word_t d);
        tag_t       t;
        index_t     ix;
        line_addr_t la;
        way_t       w;
        logic       hit;
        line_t      l;
        t   = a[ADDR_W-1 -: TAG_W];
        ix  = a[OFFSET_W +: INDEX_W];
        la  = a[ADDR_W-1:OFFSET_W];
        hit = 1'b0;
        w   = '0;
        for (int i = 0; i < NUM_WAYS; i++)
        begin
            if (ref_valid[ix][i] && ref_tag[ix][i] == t)
            begin
                hit = 1'b1;
                w   = way_t'(i);
            end
        end
        // a miss writes back a dirty victim and then fills
        if (!hit)
        begin
            w = expected_victim(ix);
            if (ref_valid[ix][w] && ref_dirty[ix][w])
            begin
                exp_mem.push_back('{rw: 1'b1, addr: {ref_tag[ix][w], ix},
                                    data: gold_line({ref_tag[ix][w], ix})});
            end
            exp_mem.push_back('{rw: 1'b0, addr: la, data: '0});
            ref_valid[ix][w] = 1'b1;
            ref_dirty[ix][w] = 1'b0;
            ref_tag[ix][w]   = t;
            ref_cnt[ix][w]   = 0;
        end
        // the final compare is always a hit
        if (ref_cnt[ix][w] == USE_MAX)
        begin
            for (int i = 0; i < NUM_WAYS; i++)
            begin
                ref_cnt[ix][i] = 0;
            end
        end
        else
        begin
            ref_cnt[ix][w]++;
        end
        if (rw)
        begin
            l = gold_line(la);
            l[a[OFFSET_W-1:0]*WORD_W +: WORD_W] = d;
            gold[la]         = l;
            ref_dirty[ix][w] = 1'b1;
            exp_rd.push_back('{rd: 1'b0, data: '0});
        end
        else
        begin
            exp_rd.push_back('{rd: 1'b1, data: expected_word(a)});
        end
    endtask

    task automatic finish_run();
        $display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // one cpu request held until the ready pulse
    task automatic access(input addr_t a, input logic rw, input word_t d);
        int cnt;
        // nothing more is issued once the cache stopped answering
        if (timeout_errors == 0)
        begin
            ref_access(a, rw, d);
            @(negedge sys_clk);
            cpu_req = '{addr: a, data: d, rw: rw, valid: 1'b1};
            cnt     = 0;
            @(negedge sys_clk);
            while (!cpu_res.ready && cnt < TIMEOUT)
            begin
                cnt++;
                @(negedge sys_clk);
            end
            if (!cpu_res.ready)
            begin
                $display("no ready pulse came back for cpu address %h", a);
                timeout_errors++;
            end
            cpu_req.valid = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin : mem_model
        mem_op_t op;
        int      delay;
        mem_resp = '0;
        mem_rng  = xorshift(SEED);
        forever
        begin
            @(negedge sys_clk);
            if (rstn && mem_req.valid)
            begin
                op = '{rw: mem_req.rw, addr: mem_req.addr, data: mem_req.data};
                got_mem.push_back(op);
                mem_rng = xorshift(mem_rng);
                delay   = int'(mem_rng % 32'd6);
                repeat (delay) @(negedge sys_clk);
                assert (mem_req.valid && mem_req.addr == op.addr && mem_req.rw == op.rw)
                else
                begin
                    $display("memory request changed before the memory answered");
                    value_errors++;
                end
                if (op.rw)
                begin
                    mem_lines[op.addr] = op.data;
                    mem_resp.data      = '0;
                end
                else
                begin
                    mem_resp.data = mem_lines.exists(op.addr) ? mem_lines[op.addr]
                                                              : pattern_line(op.addr);
                end
                mem_resp.ready = 1'b1;
                @(negedge sys_clk);
                mem_resp.ready = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge sys_clk)
    begin : compare
        mem_op_t e;
        mem_op_t g;
        rd_exp_t r;
        if (cpu_res.ready)
        begin
            if (exp_rd.size() == 0)
            begin
                $display("cpu ready pulse with no request outstanding");
                value_errors++;
            end
            else
            begin
                r = exp_rd.pop_front();
                if (r.rd)
                begin
                    assert (cpu_res.data == r.data)
                    else
                    begin
                        $display("Error: cpu_res.data got %h expected %h", cpu_res.data, r.data);
                        value_errors++;
                    end
                end
            end
        end
        while (got_mem.size() > 0)
        begin
            g = got_mem.pop_front();
            if (exp_mem.size() == 0)
            begin
                $display("memory request at line %h was not expected", g.addr);
                value_errors++;
            end
            else
            begin
                e = exp_mem.pop_front();
                assert (g.rw == e.rw)
                else
                begin
                    $display("Error: mem_req.rw got %h expected %h", g.rw, e.rw);
                    value_errors++;
                end
                assert (g.addr == e.addr)
                else
                begin
                    $display("Error: mem_req.addr got %h expected %h", g.addr, e.addr);
                    value_errors++;
                end
                assert (!e.rw || g.data == e.data)
                else
                begin
                    $display("Error: mem_req.data got %h expected %h", g.data, e.data);
                    value_errors++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin : stimulus
        int          cnt;
        way_t        v;
        tag_t        t;
        index_t      ix;
        logic [31:0] r;
        cpu_req        = '0;
        value_errors   = 0;
        timeout_errors = 0;
        stim_rng       = SEED;
        for (int s = 0; s < NUM_SETS; s++)
        begin
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
                ref_cnt[s][w]   = 0;
            end
        end
        cnt = 0;
        while (!rstn && cnt < TIMEOUT)
        begin
            cnt++;
            @(negedge sys_clk);
        end
        if (!rstn)
        begin
            $display("reset was never released");
            timeout_errors++;
        end

        // quiet outputs after reset and then a first read miss
        repeat (5)
        begin
            @(negedge sys_clk);
            assert (!cpu_res.ready)
            else
            begin
                $display("Error: cpu_res.ready got %h expected 0", cpu_res.ready);
                value_errors++;
            end
            assert (!mem_req.valid)
            else
            begin
                $display("Error: mem_req.valid got %h expected 0", mem_req.valid);
                value_errors++;
            end
        end
        access(make_addr(17'h00123, 8'h04, 2'd1), 1'b0, '0);

        // write then read back while the other words keep the pattern
        access(make_addr(17'h00123, 8'h04, 2'd1), 1'b1, 32'hDEAD_BEEF);
        access(make_addr(17'h00123, 8'h04, 2'd1), 1'b0, '0);
        access(make_addr(17'h00123, 8'h04, 2'd0), 1'b0, '0);
        access(make_addr(17'h00123, 8'h04, 2'd2), 1'b0, '0);
        access(make_addr(17'h00123, 8'h04, 2'd3), 1'b0, '0);

        // five dirty lines on one set force a write-back
        for (int i = 0; i < 5; i++)
        begin
            access(make_addr(17'h00100 + 17'(i), 8'h20, offset_t'(i)), 1'b1,
                   32'h1000_0000 + 32'(i));
        end

        // uneven use counts with one way running through the ceiling
        for (int i = 0; i < 20; i++)
        begin
            access(make_addr(17'h00102, 8'h20, 2'd0), 1'b0, '0);
        end
        access(make_addr(17'h00103, 8'h20, 2'd1), 1'b0, '0);
        access(make_addr(17'h00103, 8'h20, 2'd2), 1'b0, '0);
        access(make_addr(17'h00104, 8'h20, 2'd3), 1'b0, '0);
        v = expected_victim(8'h20);
        t = ref_tag[8'h20][v];
        access(make_addr(17'h001FF, 8'h20, 2'd0), 1'b1, 32'hCAFE_0001);
        // evicted line has to miss again
        access(make_addr(t, 8'h20, 2'd0), 1'b0, '0);

        // random mix over a few sets and tags
        repeat (300)
        begin
            stim_rng = xorshift(stim_rng);
            r        = stim_rng;
            ix       = 8'h40 + index_t'(r[3:0] % 4'd3);
            t        = 17'h02000 + tag_t'(r[7:4] % 4'd6);
            stim_rng = xorshift(stim_rng);
            access(make_addr(t, ix, r[9:8]), r[10], stim_rng);
        end

        cnt = 0;
        while ((exp_mem.size() > 0 || got_mem.size() > 0) && cnt < TIMEOUT)
        begin
            cnt++;
            @(negedge sys_clk);
        end
        if (exp_mem.size() > 0 || got_mem.size() > 0)
        begin
            $display("memory requests were left unmatched at the end of the run");
            value_errors++;
        end
        finish_run();
    end

endmodule

// File: test/tb_clock_gen.sv
// clock and reset generator of the cache testbench
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic sys_clk,
    output logic rstn
);

    initial
    begin
        sys_clk = 1'b0;
        forever #(PERIOD / 2) sys_clk = ~sys_clk;
    end

    // release on a falling edge, away from the sampling edge
    initial
    begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(negedge sys_clk);
        rstn = 1'b1;
    end

endmodule

// File: verilog/cache_top.sv
// top level of the L1 data cache with RAMs, use counters, datapath and FSM
`timescale 1ns/1ps

module cache_top
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic      sys_clk,
    input  logic      rstn,
    input  cpu_req_t  cpu_req,
    input  mem_resp_t mem_resp,
    output cpu_res_t  cpu_res,
    output mem_req_t  mem_req
);

    index_t              index;
    tag_entry_t          tag_dout [NUM_WAYS];
    line_t               line_dout [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_vec;
    logic [NUM_WAYS-1:0] tag_we;
    logic [NUM_WAYS-1:0] data_we;
    tag_entry_t          tag_din;
    line_t               data_din;
    line_t               merged_line;
    logic                data_fill;
    logic [NUM_WAYS-1:0] hit_vec;
    way_t                hit_way;
    word_t               rd_word;
    way_t                victim;
    logic                victim_dirty;
    line_addr_t          mem_addr_wb;
    line_addr_t          mem_addr_fill;
    line_t               wb_line;
    logic                hit_strobe;
    logic                fill_strobe;
    way_t                cnt_way;

    // every array is indexed by the current request
    assign index    = cpu_req.addr[OFFSET_W +: INDEX_W];
    assign data_din = data_fill ? mem_resp.data : merged_line;

    ////////////////////////////////////////////////////////////////////////////
    // tag and data arrays
    ////////////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : g_way
        way_ram #(.entry_t(tag_entry_t), .DEPTH(NUM_SETS)) u_tag_ram (
            .sys_clk (sys_clk),
            .we      (tag_we[w]),
            .index   (index),
            .din     (tag_din),
            .dout    (tag_dout[w])
        );

        way_ram #(.entry_t(line_t), .DEPTH(NUM_SETS)) u_data_ram (
            .sys_clk (sys_clk),
            .we      (data_we[w]),
            .index   (index),
            .din     (data_din),
            .dout    (line_dout[w])
        );

        assign valid_vec[w] = tag_dout[w].valid;
    end

    way_use_counters u_use_counters (
        .sys_clk     (sys_clk),
        .rstn        (rstn),
        .index       (index),
        .valid_vec   (valid_vec),
        .hit_strobe  (hit_strobe),
        .fill_strobe (fill_strobe),
        .way         (cnt_way),
        .victim      (victim)
    );

    way_datapath u_datapath (
        .req           (cpu_req),
        .tags          (tag_dout),
        .lines         (line_dout),
        .victim        (victim),
        .hit_vec       (hit_vec),
        .hit_way       (hit_way),
        .rd_word       (rd_word),
        .merged_line   (merged_line),
        .victim_dirty  (victim_dirty),
        .mem_addr_wb   (mem_addr_wb),
        .mem_addr_fill (mem_addr_fill),
        .wb_line       (wb_line)
    );

    cache_ctrl u_ctrl (
        .sys_clk       (sys_clk),
        .rstn          (rstn),
        .req           (cpu_req),
        .mem_resp      (mem_resp),
        .hit_vec       (hit_vec),
        .hit_way       (hit_way),
        .rd_word       (rd_word),
        .victim        (victim),
        .victim_dirty  (victim_dirty),
        .mem_addr_wb   (mem_addr_wb),
        .mem_addr_fill (mem_addr_fill),
        .wb_line       (wb_line),
        .res           (cpu_res),
        .mem_req       (mem_req),
        .tag_we        (tag_we),
        .tag_din       (tag_din),
        .data_we       (data_we),
        .data_fill     (data_fill),
        .hit_strobe    (hit_strobe),
        .fill_strobe   (fill_strobe),
        .cnt_way       (cnt_way)
    );

endmodule

// File: verilog/cache_ctrl.sv
// cache FSM with the cpu and memory handshakes
`timescale 1ns/1ps

module cache_ctrl
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic                sys_clk,
    input  logic                rstn,
    input  cpu_req_t            req,
    input  mem_resp_t           mem_resp,
    input  logic [NUM_WAYS-1:0] hit_vec,
    input  way_t                hit_way,
    input  word_t               rd_word,
    input  way_t                victim,
    input  logic                victim_dirty,
    input  line_addr_t          mem_addr_wb,
    input  line_addr_t          mem_addr_fill,
    input  line_t               wb_line,
    output cpu_res_t            res,
    output mem_req_t            mem_req,
    output logic [NUM_WAYS-1:0] tag_we,
    output tag_entry_t          tag_din,
    output logic [NUM_WAYS-1:0] data_we,
    output logic                data_fill,
    output logic                hit_strobe,
    output logic                fill_strobe,
    output way_t                cnt_way
);

    typedef enum logic [2:0] {
        idle,
        compare_tag,
        write_back,
        allocate,
        allocate_wait
    } state_t;

    state_t     state;
    state_t     state_next;
    logic       ready_next;
    logic       miss_capture;
    tag_t       req_tag;
    way_t       victim_q;
    line_addr_t wb_addr_q;
    line_t      wb_line_q;

    assign req_tag = req.addr[ADDR_W-1 -: TAG_W];

    ////////////////////////////////////////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next   = state;
        ready_next   = 1'b0;
        miss_capture = 1'b0;
        tag_we       = '0;
        tag_din      = '0;
        data_we      = '0;
        data_fill    = 1'b0;
        hit_strobe   = 1'b0;
        fill_strobe  = 1'b0;
        cnt_way      = victim_q;
        mem_req      = '{addr: mem_addr_fill, data: '0, rw: 1'b0, valid: 1'b0};

        case (state)
            idle:
            begin
                // skip the cycle in which the last answer is still out
                if (req.valid && !res.ready)
                begin
                    state_next = compare_tag;
                end
            end
            compare_tag:
            begin
                if (|hit_vec)
                begin
                    ready_next = 1'b1;
                    hit_strobe = 1'b1;
                    cnt_way    = hit_way;
                    if (req.rw)
                    begin
                        tag_we[hit_way]  = 1'b1;
                        tag_din          = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
                        data_we[hit_way] = 1'b1;
                    end
                    state_next = idle;
                end
                else
                begin
                    // new tag goes in clean, the write is merged on the next compare
                    tag_we[victim] = 1'b1;
                    tag_din        = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
                    miss_capture   = 1'b1;
                    state_next     = victim_dirty ? write_back : allocate;
                end
            end
            write_back:
            begin
                mem_req = '{addr: wb_addr_q, data: wb_line_q, rw: 1'b1, valid: 1'b1};
                if (mem_resp.ready)
                begin
                    state_next = allocate;
                end
            end
            allocate:
            begin
                mem_req.valid = 1'b1;
                if (mem_resp.ready)
                begin
                    data_we[victim_q] = 1'b1;
                    data_fill         = 1'b1;
                    fill_strobe       = 1'b1;
                    state_next        = allocate_wait;
                end
            end
            allocate_wait:
            begin
                // data RAM output catches up with the fill
                state_next = compare_tag;
            end
            default:
            begin
                state_next = idle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk)
    begin
        if (!rstn)
        begin
            state     <= idle;
            res.ready <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            res.ready <= ready_next;
        end
        if (ready_next)
        begin
            res.data <= rd_word;
        end
        // tag array changes after this cycle, so the victim side is frozen here
        if (miss_capture)
        begin
            victim_q  <= victim;
            wb_addr_q <= mem_addr_wb;
            wb_line_q <= wb_line;
        end
    end

endmodule

// File: verilog/way_datapath.sv
// tag compare, word select, line merge and memory request address and data
`timescale 1ns/1ps

module way_datapath
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  cpu_req_t            req,
    input  tag_entry_t          tags [NUM_WAYS],
    input  line_t               lines [NUM_WAYS],
    input  way_t                victim,
    output logic [NUM_WAYS-1:0] hit_vec,
    output way_t                hit_way,
    output word_t               rd_word,
    output line_t               merged_line,
    output logic                victim_dirty,
    output line_addr_t          mem_addr_wb,
    output line_addr_t          mem_addr_fill,
    output line_t               wb_line
);

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    line_t   hit_line;

    // split the word address
    assign req_tag    = req.addr[ADDR_W-1 -: TAG_W];
    assign req_index  = req.addr[OFFSET_W +: INDEX_W];
    assign req_offset = req.addr[OFFSET_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            hit_vec[w] = tags[w].valid && (tags[w].tag == req_tag);
        end
    end

    // encode the one-hot hit vector
    always_comb
    begin
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (hit_vec[w])
            begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_line = lines[hit_way];
    assign rd_word  = hit_line[req_offset*WORD_W +: WORD_W];

    // write word dropped into the hit line
    always_comb
    begin
        merged_line = hit_line;
        merged_line[req_offset*WORD_W +: WORD_W] = req.data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // miss side
    ////////////////////////////////////////////////////////////////////////////

    assign victim_dirty  = tags[victim].valid && tags[victim].dirty;
    // evicted line lives at the stored tag in the same set
    assign mem_addr_wb   = {tags[victim].tag, req_index};
    assign mem_addr_fill = {req_tag, req_index};
    assign wb_line       = lines[victim];

endmodule

// File: verilog/way_use_counters.sv
// per-set use counters of the four ways and the victim choice
`timescale 1ns/1ps

module way_use_counters
    import cache_cfg_pkg::*;
(
    input  logic                sys_clk,
    input  logic                rstn,
    input  index_t              index,
    input  logic [NUM_WAYS-1:0] valid_vec,
    input  logic                hit_strobe,
    input  logic                fill_strobe,
    input  way_t                way,
    output way_t                victim
);

    use_t cnt [NUM_SETS][NUM_WAYS];

    ////////////////////////////////////////////////////////////////////////////
    // counter update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk)
    begin
        if (!rstn)
        begin
            cnt <= '{default: '0};
        end
        else if (hit_strobe)
        begin
            // a hit at the ceiling restarts the whole set
            if (cnt[index][way] == use_t'(USE_MAX))
            begin
                for (int w = 0; w < NUM_WAYS; w++)
                begin
                    cnt[index][w] <= '0;
                end
            end
            else
            begin
                cnt[index][way] <= cnt[index][way] + 1'b1;
            end
        end
        else if (fill_strobe)
        begin
            cnt[index][way] <= '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // victim choice
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin : victim_sel
        use_t min_cnt;
        logic found;
        victim  = '0;
        found   = 1'b0;
        min_cnt = cnt[index][0];
        // lowest invalid way first
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (!valid_vec[w] && !found)
            begin
                victim = way_t'(w);
                found  = 1'b1;
            end
        end
        // otherwise the lowest count with a tie kept on the lower index
        if (!found)
        begin
            for (int w = 1; w < NUM_WAYS; w++)
            begin
                if (cnt[index][w] < min_cnt)
                begin
                    min_cnt = cnt[index][w];
                    victim  = way_t'(w);
                end
            end
        end
    end

endmodule

// File: verilog/way_ram.sv
// single-port synchronous RAM with read-first registered output
`timescale 1ns/1ps

module way_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 256
) (
    input  bit                       sys_clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] index,
    input  entry_t                   din,
    output entry_t                   dout
);

    // all entries start out as zero, so every way begins invalid
    entry_t mem [DEPTH] = '{default: '0};

    always_ff @(posedge sys_clk)
    begin
        if (we)
        begin
            mem[index] <= din;
        end
        // old contents come out on a write to the same entry
        dout <= mem[index];
    end

endmodule

// File: verilog/cache_bus_pkg.sv
// request and response structs of the cpu and memory ports, tag entry struct
package cache_bus_pkg;

    import cache_cfg_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // cpu side
    ////////////////////////////////////////////////////////////////////////////

    // rw = 1 means write
    typedef struct packed {
        addr_t addr;
        word_t data;
        logic  rw;
        logic  valid;
    } cpu_req_t;

    typedef struct packed {
        word_t data;
        logic  ready;
    } cpu_res_t;

    ////////////////////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////////////////////

    // memory is addressed in whole lines
    localparam int LINE_ADDR_W = TAG_W + INDEX_W;

    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    typedef struct packed {
        line_addr_t addr;
        line_t      data;
        logic       rw;
        logic       valid;
    } mem_req_t;

    typedef struct packed {
        line_t data;
        logic  ready;
    } mem_resp_t;

    // one entry of a tag array
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

endpackage

// File: verilog/cache_cfg_pkg.sv
// geometry localparams and address field types of the L1 data cache
package cache_cfg_pkg;

    // word address = {tag, index, word offset}
    localparam int ADDR_W   = 27;
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // four ways, 256 sets
    localparam int NUM_WAYS = 4;
    localparam int WAY_W    = 2;
    localparam int NUM_SETS = 1 << INDEX_W;

    // one line holds four cpu words
    localparam int WORD_W   = 32;
    localparam int LINE_W   = WORD_W << OFFSET_W;

    // per-way use counter
    localparam int USE_W    = 4;
    localparam int USE_MAX  = 15;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [WAY_W-1:0]    way_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [USE_W-1:0]    use_t;

endpackage
